// File: hw/periph_bus_pkg.sv
package periph_bus_pkg;

    // Core request codes, active low
    localparam logic [1:0] req_none = 2'b11;
    localparam logic [1:0] req_byte = 2'b00;
    localparam logic [1:0] req_half = 2'b01;
    localparam logic [1:0] req_word = 2'b10;

    // Populated slots, anything above reads as empty
    localparam int n_user_slots        = 4;
    localparam int n_simple_slots      = 4;
    localparam int gpio_slot           = 1;
    localparam int first_ext_user_slot = 2;
    localparam int n_ext_user_slots    = n_user_slots - first_ext_user_slot;

    // Pin function select encoding
    localparam int         fsel_simple_bit = 4;     // Set for the byte slot region
    localparam logic [4:0] fsel_reset_uart = 5'd2;  // Pins 0 and 1
    localparam logic [4:0] fsel_reset_gpio = 5'd1;  // Pins 2 to 7

    // GPIO register map
    localparam logic [5:0] gpio_reg_out   = 6'h00;
    localparam logic [5:0] gpio_reg_in    = 6'h04;
    localparam logic [5:0] gpio_reg_audio = 6'h10;
    localparam logic [5:0] gpio_fsel_base = 6'h20;  // One word per pin up to 0x3C

    // Peripheral address, decoded as a full slot or a byte slot
    typedef union packed {
        struct packed {
            logic       region;   // 0 here
            logic [3:0] slot;
            logic [5:0] reg_off;
        } user;
        struct packed {
            logic       region;   // 1 here
            logic [1:0] spare;
            logic [3:0] slot;
            logic [3:0] reg_off;
        } simple;
    } periph_addr_t;

endpackage

// File: hw/periph_addr_decode.sv
`timescale 1ns/1ps

module periph_addr_decode import periph_bus_pkg::*; (
    input  periph_addr_t                         i_addr,
    input  logic [1:0]                           i_write_n,
    input  logic [1:0]                           i_read_n_masked,
    input  logic [31:0]                          i_gpio_rdata,
    input  logic [n_ext_user_slots-1:0][31:0]    i_user_rdata,
    input  logic [n_ext_user_slots-1:0]          i_user_ready,
    input  logic [n_simple_slots-1:0][7:0]       i_simple_rdata,
    output logic                                 o_gpio_sel,
    output logic                                 o_gpio_write,
    output logic [n_ext_user_slots-1:0][1:0]     o_user_write_n,
    output logic [n_ext_user_slots-1:0][1:0]     o_user_read_n,
    output logic [n_simple_slots-1:0]            o_simple_write,
    output logic [31:0]                          o_sel_rdata,
    output logic                                 o_sel_ready
);

    logic                         write_req;
    logic [n_ext_user_slots-1:0]  ext_sel;
    logic [n_simple_slots-1:0]    simple_sel;

    assign write_req = i_write_n != req_none;

    always_comb begin
        o_gpio_sel  = 1'b0;
        ext_sel     = '0;
        simple_sel  = '0;
        o_sel_rdata = '0;
        o_sel_ready = 1'b1;   // Reserved and empty slots answer zero at once

        if (i_addr.simple.region) begin
            // Byte slots are always ready
            for (int s = 0; s < n_simple_slots; s++) begin
                if (i_addr.simple.slot == 4'(s)) begin
                    simple_sel[s] = 1'b1;
                    o_sel_rdata   = {24'h0, i_simple_rdata[s]};
                end
            end
        end else begin
            if (i_addr.user.slot == 4'(gpio_slot)) begin
                o_gpio_sel  = 1'b1;
                o_sel_rdata = i_gpio_rdata;
            end
            for (int s = 0; s < n_ext_user_slots; s++) begin
                if (i_addr.user.slot == 4'(first_ext_user_slot + s)) begin
                    ext_sel[s]  = 1'b1;
                    o_sel_rdata = i_user_rdata[s];
                    o_sel_ready = i_user_ready[s];   // External latency varies
                end
            end
        end
    end

    // Unselected slots only ever see req_none
    always_comb begin
        for (int s = 0; s < n_ext_user_slots; s++) begin
            o_user_write_n[s] = ext_sel[s] ? i_write_n : req_none;
            o_user_read_n[s]  = ext_sel[s] ? i_read_n_masked : req_none;
        end
    end

    assign o_gpio_write   = o_gpio_sel & write_req;
    assign o_simple_write = simple_sel & {n_simple_slots{write_req}};

    always_comb begin
        assert final ($onehot0({o_gpio_sel, ext_sel, simple_sel}))
            else $error("More than one peripheral slot selected");
    end

endmodule

// File: hw/periph_read_buffer.sv
`timescale 1ns/1ps

module periph_read_buffer import periph_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [1:0]  i_read_n,
    input  logic [1:0]  i_write_n,
    input  logic [31:0] i_sel_rdata,
    input  logic        i_sel_ready,
    input  logic        i_read_complete,
    output logic [1:0]  o_read_n_masked,
    output logic [31:0] o_rdata,
    output logic        o_data_ready
);

    logic read_req;
    logic capture;
    logic hold;      // Result owned by the core until read complete
    logic ready_r;

    assign read_req = i_read_n != req_none;
    assign capture  = !hold && read_req && i_sel_ready;

    // No second read reaches the slot while the result is presented
    assign o_read_n_masked = i_read_n | {2{ready_r}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete)
                hold <= 1'b0;
            if (capture)
                hold <= 1'b1;   // Wins over a complete in the same cycle
            ready_r <= read_req && i_sel_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture)
            o_rdata <= i_sel_rdata;
    end

    // Writes finish in the cycle they are issued
    assign o_data_ready = ready_r || (i_write_n != req_none);

    // A captured result must come from a read that the slot actually saw
    hold_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(hold) |-> $past((o_read_n_masked != req_none) && i_sel_ready))
        else $error("Read result captured without a read request");

endmodule

// File: hw/gpio_config.sv
`timescale 1ns/1ps

module gpio_config import periph_bus_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_sel,
    input  logic            i_write,
    input  logic [5:0]      i_reg,
    input  logic [31:0]     i_wdata,
    input  logic [7:0]      i_ui_in,
    output logic [7:0]      o_gpio_out,
    output logic [7:0][4:0] o_pin_fsel,
    output logic [2:0]      o_audio_fsel,
    output logic [31:0]     o_rdata
);

    logic       fsel_hit;
    logic [2:0] fsel_idx;

    // Word aligned offsets from 0x20 up hold the pin selects
    assign fsel_hit = (i_reg[1:0] == 2'b00) && (i_reg >= gpio_fsel_base);
    assign fsel_idx = i_reg[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out   <= '0;
            o_audio_fsel <= '0;
            for (int p = 0; p < 8; p++) begin
                // Pins 0 and 1 start on the UART slot
                o_pin_fsel[p] <= (p < 2) ? fsel_reset_uart : fsel_reset_gpio;
            end
        end else if (i_write) begin
            if (i_reg == gpio_reg_out)
                o_gpio_out <= i_wdata[7:0];
            if (i_reg == gpio_reg_audio)
                o_audio_fsel <= i_wdata[2:0];
            if (fsel_hit)
                o_pin_fsel[fsel_idx] <= i_wdata[4:0];
        end
    end

    // Readback, zero for unknown offsets
    always_comb begin
        o_rdata = '0;
        if (i_sel) begin
            if (i_reg == gpio_reg_out)
                o_rdata[7:0] = o_gpio_out;
            else if (i_reg == gpio_reg_in)
                o_rdata[7:0] = i_ui_in;      // Synchronized input pins
            else if (i_reg == gpio_reg_audio)
                o_rdata[2:0] = o_audio_fsel;
            else if (fsel_hit)
                o_rdata[4:0] = o_pin_fsel[fsel_idx];
        end
    end

endmodule

// File: hw/pin_func_mux.sv
`timescale 1ns/1ps

module pin_func_mux import periph_bus_pkg::*; (
    input  logic                                clk,
    input  logic [7:0][4:0]                     i_pin_fsel,
    input  logic [2:0]                          i_audio_fsel,
    input  logic [7:0]                          i_gpio_out,
    input  logic [n_ext_user_slots-1:0][7:0]    i_user_uo,
    input  logic [n_simple_slots-1:0][7:0]      i_simple_uo,
    output logic [7:0]                          o_uo_out,
    output logic                                o_audio,
    output logic                                o_audio_select
);

    for (genvar p = 0; p < 8; p++) begin : g_pin
        logic [3:0] slot;

        assign slot = i_pin_fsel[p][3:0];

        // Each pin takes only its own bit of the chosen slot
        always_comb begin
            o_uo_out[p] = 1'b0;   // Unpopulated slot
            if (i_pin_fsel[p][fsel_simple_bit]) begin
                for (int s = 0; s < n_simple_slots; s++) begin
                    if (slot == 4'(s))
                        o_uo_out[p] = i_simple_uo[s][p];
                end
            end else begin
                if (slot == 4'(gpio_slot))
                    o_uo_out[p] = i_gpio_out[p];
                for (int s = 0; s < n_ext_user_slots; s++) begin
                    if (slot == 4'(first_ext_user_slot + s))
                        o_uo_out[p] = i_user_uo[s][p];
                end
            end
        end
    end

    // Audio bit from a fixed set of source pins
    always_ff @(posedge clk) begin
        case (i_audio_fsel[1:0])
            2'd0:    o_audio <= i_user_uo[0][7];     // User slot 2
            2'd1:    o_audio <= i_user_uo[0][6];     // User slot 2
            2'd2:    o_audio <= i_simple_uo[2][7];
            default: o_audio <= i_simple_uo[3][7];
        endcase
    end

    assign o_audio_select = i_audio_fsel[2];

endmodule

// File: hw/periph_fabric_top.sv
`timescale 1ns/1ps

module periph_fabric_top import periph_bus_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,

    // Core side
    input  periph_addr_t                        i_addr,
    input  logic [31:0]                         i_wdata,
    input  logic [1:0]                          i_write_n,
    input  logic [1:0]                          i_read_n,
    output logic [31:0]                         o_rdata,
    output logic                                o_data_ready,
    input  logic                                i_read_complete,

    // Pins
    input  logic [7:0]                          i_ui_in,
    output logic [7:0]                          o_uo_out,
    output logic                                o_audio,
    output logic                                o_audio_select,

    // Shared to all slots
    output logic [5:0]                          o_slot_reg,
    output logic [31:0]                         o_slot_wdata,

    // External full slots, user 2 and 3
    output logic [n_ext_user_slots-1:0][1:0]    o_user_write_n,
    output logic [n_ext_user_slots-1:0][1:0]    o_user_read_n,
    input  logic [n_ext_user_slots-1:0][31:0]   i_user_rdata,
    input  logic [n_ext_user_slots-1:0]         i_user_ready,
    input  logic [n_ext_user_slots-1:0][7:0]    i_user_uo,

    // Byte slots 0 to 3
    output logic [n_simple_slots-1:0]           o_simple_write,
    input  logic [n_simple_slots-1:0][7:0]      i_simple_rdata,
    input  logic [n_simple_slots-1:0][7:0]      i_simple_uo
);

    logic [1:0]      read_n_masked;
    logic            gpio_sel;
    logic            gpio_write;
    logic [31:0]     gpio_rdata;
    logic [31:0]     sel_rdata;
    logic            sel_ready;
    logic [7:0]      gpio_out;
    logic [7:0][4:0] pin_fsel;
    logic [2:0]      audio_fsel;

    assign o_slot_reg   = i_addr.user.reg_off;   // Byte slots use the low 4 bits
    assign o_slot_wdata = i_wdata;

    periph_addr_decode i_decode (
        .i_addr          (i_addr),
        .i_write_n       (i_write_n),
        .i_read_n_masked (read_n_masked),
        .i_gpio_rdata    (gpio_rdata),
        .i_user_rdata    (i_user_rdata),
        .i_user_ready    (i_user_ready),
        .i_simple_rdata  (i_simple_rdata),
        .o_gpio_sel      (gpio_sel),
        .o_gpio_write    (gpio_write),
        .o_user_write_n  (o_user_write_n),
        .o_user_read_n   (o_user_read_n),
        .o_simple_write  (o_simple_write),
        .o_sel_rdata     (sel_rdata),
        .o_sel_ready     (sel_ready)
    );

    periph_read_buffer i_read_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_sel_rdata     (sel_rdata),
        .i_sel_ready     (sel_ready),
        .i_read_complete (i_read_complete),
        .o_read_n_masked (read_n_masked),
        .o_rdata         (o_rdata),
        .o_data_ready    (o_data_ready)
    );

    gpio_config i_gpio (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_sel        (gpio_sel),
        .i_write      (gpio_write),
        .i_reg        (i_addr.user.reg_off),
        .i_wdata      (i_wdata),
        .i_ui_in      (i_ui_in),
        .o_gpio_out   (gpio_out),
        .o_pin_fsel   (pin_fsel),
        .o_audio_fsel (audio_fsel),
        .o_rdata      (gpio_rdata)
    );

    pin_func_mux i_pin_mux (
        .clk            (clk),
        .i_pin_fsel     (pin_fsel),
        .i_audio_fsel   (audio_fsel),
        .i_gpio_out     (gpio_out),
        .i_user_uo      (i_user_uo),
        .i_simple_uo    (i_simple_uo),
        .o_uo_out       (o_uo_out),
        .o_audio        (o_audio),
        .o_audio_select (o_audio_select)
    );

endmodule

// File: test/periph_fabric_checker.sv
`timescale 1ns/1ps

module periph_fabric_checker import periph_bus_pkg::*; (
    input  logic                             clk,
    input  logic                             i_chk_write,
    input  logic                             i_chk_read,
    input  logic                             i_chk_pins,
    input  logic                             i_chk_audio,
    input  logic [31:0]                      i_expected,
    input  logic [2*n_ext_user_slots-1:0]    i_exp_user_write,
    input  int                               i_latency,
    input  logic [31:0]                      i_wdata,
    input  logic [31:0]                      i_rdata,
    input  logic                             i_data_ready,
    input  logic                             i_read_complete,
    input  logic [7:0]                       i_uo_out,
    input  logic                             i_audio,
    input  logic                             i_audio_select,
    input  logic [n_simple_slots-1:0]        i_simple_write,
    input  logic [n_ext_user_slots-1:0][1:0] i_user_write_n,
    input  logic [31:0]                      i_slot_wdata,
    output int                               o_checks,
    output int                               o_errors
);

    localparam int rd_idle = 0;
    localparam int rd_wait = 1;
    localparam int rd_hold = 2;   // Result owned by the core
    localparam int rd_done = 3;

    int rd_state = rd_idle;
    int waited   = 0;

    initial begin
        $timeformat(-9, 0, " ns", 10);
        o_checks = 0;
        o_errors = 0;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        o_checks++;
        if (actual !== expected) begin
            o_errors++;
            $display("FAIL %t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // Outputs are settled half a cycle after the driving edge
    always @(negedge clk) begin
        if (i_chk_write) begin
            compare("o_simple_write", i_expected, 32'(i_simple_write));
            compare("o_user_write_n", 32'(i_exp_user_write), 32'(i_user_write_n));
            compare("o_slot_wdata", i_wdata, i_slot_wdata);
            compare("o_data_ready", 32'd1, 32'(i_data_ready));   // Same cycle ack
        end
        if (i_chk_pins) begin
            compare("o_uo_out", i_expected, 32'(i_uo_out));
            compare("o_data_ready", 32'd0, 32'(i_data_ready));   // Idle bus
        end
        if (i_chk_audio)
            compare("{o_audio_select, o_audio}", i_expected, {30'd0, i_audio_select, i_audio});

        if (!i_chk_read) begin
            rd_state = rd_idle;
            waited   = 0;
        end else if (rd_state == rd_idle || rd_state == rd_wait) begin
            if (i_data_ready) begin
                compare("o_rdata", i_expected, i_rdata);
                compare("o_data_ready delay", i_latency + 1, waited);
                rd_state = rd_hold;
            end else begin
                rd_state = rd_wait;
                waited++;
                if (waited == 32) begin
                    o_errors++;
                    $display("Read got no o_data_ready within 32 cycles at %t", $time);
                end
            end
        end else if (rd_state == rd_hold) begin
            compare("o_rdata", i_expected, i_rdata);   // Must not move while held
            if (i_read_complete)
                rd_state = rd_done;
        end
    end

endmodule

// File: test/tb_periph_fabric.sv
`timescale 1ns/1ps

module tb_periph_fabric import periph_bus_pkg::*; ();

    // Signals carry the DUT port names so the instance connects by name
    logic                              clk = 1'b0;
    logic                              rst_n;
    periph_addr_t                      i_addr;
    logic [31:0]                       i_wdata;
    logic [1:0]                        i_write_n;
    logic [1:0]                        i_read_n;
    logic                              i_read_complete;
    logic [7:0]                        i_ui_in;
    logic [31:0]                       o_rdata;
    logic                              o_data_ready;
    logic [7:0]                        o_uo_out;
    logic                              o_audio;
    logic                              o_audio_select;
    logic [5:0]                        o_slot_reg;
    logic [31:0]                       o_slot_wdata;
    logic [n_ext_user_slots-1:0][1:0]  o_user_write_n;
    logic [n_ext_user_slots-1:0][1:0]  o_user_read_n;
    logic [n_ext_user_slots-1:0][31:0] i_user_rdata;
    logic [n_ext_user_slots-1:0]       i_user_ready;
    logic [n_ext_user_slots-1:0][7:0]  i_user_uo;
    logic [n_simple_slots-1:0]         o_simple_write;
    logic [n_simple_slots-1:0][7:0]    i_simple_rdata;
    logic [n_simple_slots-1:0][7:0]    i_simple_uo;

    logic                              chk_write;
    logic                              chk_read;
    logic                              chk_pins;
    logic                              chk_audio;
    logic [31:0]                       chk_exp;
    logic [2*n_ext_user_slots-1:0]     chk_user_wr;
    int                                latency;      // Delay of the external slot models
    int                                checks;
    int                                errors;
    int                                bad_ops = 0;
    int                                cycles = 0;
    int                                cycle_limit = 0;
    integer                            seed = 32'h43b6;

    // Operations from the stimulus file
    logic [7:0]  op_q[$];
    logic [10:0] addr_q[$];
    logic [31:0] data_q[$];
    logic [1:0]  size_q[$];
    logic [31:0] exp_q[$];
    int          lat_q[$];

    always #4 clk = ~clk;

    periph_fabric_top i_dut (.*);

    periph_fabric_checker i_checker (
        .clk              (clk),
        .i_chk_write      (chk_write),
        .i_chk_read       (chk_read),
        .i_chk_pins       (chk_pins),
        .i_chk_audio      (chk_audio),
        .i_expected       (chk_exp),
        .i_exp_user_write (chk_user_wr),
        .i_latency        (latency),
        .i_wdata          (i_wdata),
        .i_rdata          (o_rdata),
        .i_data_ready     (o_data_ready),
        .i_read_complete  (i_read_complete),
        .i_uo_out         (o_uo_out),
        .i_audio          (o_audio),
        .i_audio_select   (o_audio_select),
        .i_simple_write   (o_simple_write),
        .i_user_write_n   (o_user_write_n),
        .i_slot_wdata     (o_slot_wdata),
        .o_checks         (checks),
        .o_errors         (errors)
    );

    // Pin patterns, audio sources flip from one source to the next
    assign i_user_uo   = {8'h5a, 8'h83};                  // User 3, user 2
    assign i_simple_uo = {8'h43, 8'hbc, 8'hf0, 8'h0f};    // Simple 3 down to 0

    for (genvar s = 0; s < n_ext_user_slots; s++) begin : g_user
        logic [31:0] value;
        int          cnt = 0;

        assign value = {8'(first_ext_user_slot + s), 16'h0, 2'b00, o_slot_reg};
        // Data turns to garbage once the read code goes away
        assign i_user_rdata[s] = (o_user_read_n[s] != req_none) ? value : ~value;
        assign i_user_ready[s] = (o_user_read_n[s] != req_none) && (cnt >= latency);

        always @(posedge clk) begin
            cnt <= (o_user_read_n[s] == req_none) ? 0 : cnt + 1;
        end
    end

    for (genvar s = 0; s < n_simple_slots; s++) begin : g_simple
        assign i_simple_rdata[s] = 8'h50 + 8'(s);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the bus stopped answering", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors + bad_ops);
            $display("Test FAILED");
            $finish;
        end
    end

    // Only the addressed full slot sees the write code, the others see none
    function automatic logic [2*n_ext_user_slots-1:0] user_write_codes(
            input logic [10:0] a, input logic [1:0] size);
        logic [2*n_ext_user_slots-1:0] codes;
        int                            slot;
        codes = '1;
        slot  = int'(a[9:6]) - first_ext_user_slot;
        if (!a[10] && slot >= 0 && slot < n_ext_user_slots)
            codes[2*slot +: 2] = size;
        return codes;
    endfunction

    task automatic load_stimulus(output bit ok);
        integer          fd;
        int              n;
        logic [8*96-1:0] line_buf;
        logic [7:0]      op;
        logic [31:0]     a, d, sz, e, l;
        fd = $fopen("test/periph_stimulus.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line_buf, fd) != 0) begin
                n = $sscanf(line_buf, "%s %h %h %h %h %h", op, a, d, sz, e, l);
                if (n == 6 && op != "#") begin
                    op_q.push_back(op);
                    addr_q.push_back(a[10:0]);
                    data_q.push_back(d);
                    size_q.push_back(sz[1:0]);
                    exp_q.push_back(e);
                    lat_q.push_back(l);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic bus_write(input logic [10:0] a, input logic [31:0] d,
                             input logic [1:0] size, input logic [31:0] expected);
        @(posedge clk);
        i_addr      <= a;
        i_wdata     <= d;
        i_write_n   <= size;
        chk_exp     <= expected;
        chk_user_wr <= user_write_codes(a, size);
        chk_write   <= 1'b1;
        @(posedge clk);
        i_write_n <= req_none;
        chk_write <= 1'b0;
    endtask

    task automatic bus_read(input logic [10:0] a, input logic [1:0] size,
                            input logic [31:0] expected, input int lat);
        @(posedge clk);
        i_addr   <= a;
        i_read_n <= size;
        latency  <= lat;
        chk_exp  <= expected;
        chk_read <= 1'b1;
        do @(negedge clk); while (!o_data_ready);
        @(posedge clk);
        i_read_n <= req_none;
        repeat (3) @(posedge clk);   // Core leaves the result unclaimed for a while
        i_read_complete <= 1'b1;
        @(posedge clk);
        i_read_complete <= 1'b0;
        chk_read        <= 1'b0;
    endtask

    task automatic check_outputs(input bit pins, input logic [31:0] expected);
        @(posedge clk);
        chk_exp   <= expected;
        chk_pins  <= pins;
        chk_audio <= !pins;
        @(posedge clk);
        chk_pins  <= 1'b0;
        chk_audio <= 1'b0;
    endtask

    task automatic run_stimulus();
        int lat;
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "W": bus_write(addr_q[i], data_q[i], size_q[i], exp_q[i]);
                "R": begin
                    // ff draws the delay at random
                    lat = (lat_q[i] == 255) ? $unsigned($random(seed)) % 6 : lat_q[i];
                    bus_read(addr_q[i], size_q[i], exp_q[i], lat);
                end
                "P": check_outputs(1'b1, exp_q[i]);
                "A": check_outputs(1'b0, exp_q[i]);
                default: begin
                    $display("Unknown operation in line %0d of the stimulus", i);
                    bad_ops++;
                end
            endcase
        end
    endtask

    initial begin
        bit ok;
        rst_n           = 1'b0;
        i_addr          = '0;
        i_wdata         = '0;
        i_write_n       = req_none;
        i_read_n        = req_none;
        i_read_complete = 1'b0;
        i_ui_in         = 8'ha7;
        chk_write       = 1'b0;
        chk_read        = 1'b0;
        chk_pins        = 1'b0;
        chk_audio       = 1'b0;
        chk_exp         = '0;
        chk_user_wr     = '1;
        latency         = 0;
        load_stimulus(ok);
        if (!ok) begin
            $display("Cannot open the stimulus file test/periph_stimulus.txt");
            $display("Test FAILED");
            $finish;
        end else begin
            cycle_limit = op_q.size() * 40;
            repeat (10) @(posedge clk);
            rst_n <= 1'b1;
            run_stimulus();
            repeat (2) @(posedge clk);
            $display("Checks: %0d, errors: %0d", checks, errors + bad_ops);
            if (errors + bad_ops == 0)
                $display("Test OK");
            else
                $display("Test FAILED");
            $finish;
        end
    end

endmodule

// File: test/periph_stimulus.txt
# op addr data size expected latency, all hex, latency ff draws a random delay
# W gives byte slot strobes, R read data, P pins, A {audio select, audio}
P 000 00000000 3 00000003 0
A 000 00000000 3 00000001 0
W 040 00000058 2 00000000 0
R 040 00000000 2 00000058 0
R 044 00000000 2 000000a7 0
P 000 00000000 3 0000005b 0
R 08c 00000000 2 0200000c 3
R 0c4 00000000 2 03000004 ff
R 094 00000000 0 02000014 0
R 0cc 00000000 2 0300000c ff
R 420 00000000 0 00000052 0
R 437 00000000 0 00000053 0
R 140 00000000 2 00000000 0
R 004 00000000 2 00000000 0
W 410 000000aa 0 00000002 0
W 438 00000011 0 00000008 0
W 06c 00000013 2 00000000 0
R 06c 00000000 2 00000013 0
P 000 00000000 3 00000053 0
W 070 00000017 2 00000000 0
P 000 00000000 3 00000043 0
W 050 00000001 2 00000000 0
A 000 00000000 3 00000000 0
W 050 00000002 2 00000000 0
A 000 00000000 3 00000001 0
W 050 00000003 2 00000000 0
A 000 00000000 3 00000000 0
W 050 00000004 2 00000000 0
A 000 00000000 3 00000003 0
W 050 00000005 2 00000000 0
A 000 00000000 3 00000002 0
R 050 00000000 2 00000005 0

// File: all.f
hw/periph_bus_pkg.sv
hw/periph_addr_decode.sv
hw/periph_read_buffer.sv
hw/gpio_config.sv
hw/pin_func_mux.sv
hw/periph_fabric_top.sv
test/periph_fabric_checker.sv
test/tb_periph_fabric.sv
